//--- common/loader_pkg.sv
package loader_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int XLEN = 32;

typedef logic [XLEN-1:0] word_t;    // data word or byte address
typedef logic [7:0]      byte_t;

localparam int RAM_WORDS = 1024;    // 4 KB of RAM
localparam int RAM_AW    = 10;      // word index, byte addresses wrap at 4 KB

// kept low so a simulated frame is short, a board build raises it
localparam int BAUD_DIV = 8;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host protocol
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

typedef enum logic [7:0] {
    CMD_WRITE = 8'h01,
    CMD_READ  = 8'h02,
    CMD_RUN   = 8'h03,
    CMD_HALT  = 8'h04
} cmd_e;

localparam byte_t RSP_FAULT = 8'hEE;
localparam byte_t RSP_NAK   = 8'hFF;

endpackage

//--- uart/uart_rx.sv
module uart_rx (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              uart_rx_i,
    input  logic              uart_rx_data_rdy_i,

    output loader_pkg::byte_t uart_rx_data_o,
    output logic              uart_rx_data_vld_o
);

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} rx_state_t;

rx_state_t state;

logic rx_meta;
logic rx_sync;

logic [$clog2(loader_pkg::BAUD_DIV)-1:0] baud_cnt;
logic                                    baud_tick;
logic [2:0]                              bit_idx;

loader_pkg::byte_t shift_q;

assign baud_tick = (baud_cnt == '0);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rx_meta            <= 1'b1;
        rx_sync            <= 1'b1;
        state              <= RX_IDLE;
        baud_cnt           <= '0;
        bit_idx            <= '0;
        uart_rx_data_vld_o <= 1'b0;
    end else begin
        rx_meta <= uart_rx_i;
        rx_sync <= rx_meta;

        if (uart_rx_data_vld_o && uart_rx_data_rdy_i) begin
            uart_rx_data_vld_o <= 1'b0;
        end

        if (state != RX_IDLE && !baud_tick) begin
            baud_cnt <= baud_cnt - 1'b1;
        end

        case (state)
            RX_IDLE: begin
                if (!rx_sync) begin
                    // half a bit first so later samples land mid-bit
                    baud_cnt <= $bits(baud_cnt)'(loader_pkg::BAUD_DIV / 2 - 1);
                    state    <= RX_START;
                end
            end
            RX_START: begin
                if (baud_tick) begin
                    if (rx_sync) begin
                        state <= RX_IDLE;   // line went back high, only a glitch
                    end else begin
                        baud_cnt <= $bits(baud_cnt)'(loader_pkg::BAUD_DIV - 1);
                        bit_idx  <= '0;
                        state    <= RX_DATA;
                    end
                end
            end
            RX_DATA: begin
                if (baud_tick) begin
                    shift_q  <= {rx_sync, shift_q[7:1]};    // lsb arrives first
                    baud_cnt <= $bits(baud_cnt)'(loader_pkg::BAUD_DIV - 1);
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= RX_STOP;
                    end
                end
            end
            default: begin
                if (baud_tick) begin
                    state <= RX_IDLE;
                    // a byte still waiting for the engine wins over the new one
                    if (rx_sync && (!uart_rx_data_vld_o || uart_rx_data_rdy_i)) begin
                        uart_rx_data_o     <= shift_q;
                        uart_rx_data_vld_o <= 1'b1;
                    end
                end
            end
        endcase
    end
end

endmodule

//--- uart/uart_tx.sv
module uart_tx (
    input  logic              clk_i,
    input  logic              reset_i,

    input  loader_pkg::byte_t uart_tx_data_i,
    input  logic              uart_tx_data_vld_i,

    output logic              uart_tx_o,
    output logic              uart_tx_data_rdy_o
);

logic [9:0] frame_q;    // stop, data, start with the start bit at bit 0
logic       busy;
logic [3:0] bit_cnt;

logic [$clog2(loader_pkg::BAUD_DIV)-1:0] baud_cnt;

assign uart_tx_o          = frame_q[0];
assign uart_tx_data_rdy_o = ~busy;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        frame_q  <= '1;     // line idles high
        busy     <= 1'b0;
        bit_cnt  <= '0;
        baud_cnt <= '0;
    end else if (!busy) begin
        if (uart_tx_data_vld_i) begin
            frame_q  <= {1'b1, uart_tx_data_i, 1'b0};
            busy     <= 1'b1;
            bit_cnt  <= '0;
            baud_cnt <= $bits(baud_cnt)'(loader_pkg::BAUD_DIV - 1);
        end
    end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
    end else if (bit_cnt == 4'd9) begin
        busy <= 1'b0;   // stop bit has had its full length
    end else begin
        // ones shift in behind the frame so the line rests high
        frame_q  <= {1'b1, frame_q[9:1]};
        bit_cnt  <= bit_cnt + 1'b1;
        baud_cnt <= $bits(baud_cnt)'(loader_pkg::BAUD_DIV - 1);
    end
end

endmodule

//--- logic/ram.sv
module ram (
    input  logic              clk_i,

    input  logic              ram_rw_sel_i,
    input  loader_pkg::word_t ram_rw_addr_i,
    input  loader_pkg::word_t ram_wr_data_i,
    input  logic [3:0]        ram_wr_byte_en_i,

    input  loader_pkg::word_t dram_rd_addr_i,
    input  loader_pkg::word_t dram_wr_addr_i,
    input  loader_pkg::word_t dram_wr_data_i,
    input  logic [3:0]        dram_wr_byte_en_i,

    input  loader_pkg::word_t iram_rd_addr_i,

    output loader_pkg::word_t iram_rd_data_o,
    output loader_pkg::word_t dram_rd_data_o
);

loader_pkg::word_t mem [loader_pkg::RAM_WORDS];

logic [loader_pkg::RAM_AW-1:0] iram_idx;
logic [loader_pkg::RAM_AW-1:0] drd_idx;
logic [loader_pkg::RAM_AW-1:0] dwr_idx;

loader_pkg::word_t wr_data;
logic [3:0]        wr_be;

assign iram_idx = iram_rd_addr_i[loader_pkg::RAM_AW+1:2];

// the loader owns the data port whenever the CPU is held
assign drd_idx = ram_rw_sel_i ? ram_rw_addr_i[loader_pkg::RAM_AW+1:2]
                              : dram_rd_addr_i[loader_pkg::RAM_AW+1:2];
assign dwr_idx = ram_rw_sel_i ? ram_rw_addr_i[loader_pkg::RAM_AW+1:2]
                              : dram_wr_addr_i[loader_pkg::RAM_AW+1:2];
assign wr_data = ram_rw_sel_i ? ram_wr_data_i : dram_wr_data_i;
assign wr_be   = ram_rw_sel_i ? ram_wr_byte_en_i : dram_wr_byte_en_i;

always_ff @(posedge clk_i) begin
    iram_rd_data_o <= mem[iram_idx];
    dram_rd_data_o <= mem[drd_idx];     // old word on a same-address write
    for (int b = 0; b < 4; b++) begin
        if (wr_be[b]) begin
            mem[dwr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
    end
end

endmodule

//--- logic/ram_rw.sv
module ram_rw (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              cpu_fault_i,

    input  loader_pkg::byte_t uart_rx_data_i,
    input  logic              uart_rx_data_vld_i,
    output logic              uart_rx_data_rdy_o,

    output loader_pkg::byte_t uart_tx_data_o,
    output logic              uart_tx_data_vld_o,
    input  logic              uart_tx_data_rdy_i,

    input  loader_pkg::word_t ram_rd_data_i,

    output logic              ram_rw_sel_o,
    output loader_pkg::word_t ram_rw_addr_o,
    output loader_pkg::word_t ram_wr_data_o,
    output logic [3:0]        ram_wr_byte_en_o,

    output logic              cpu_run_o
);

typedef enum logic [2:0] {
    S_OP,
    S_ADDR,
    S_CNT,
    S_WDATA,
    S_WSTORE,
    S_RADDR,
    S_RCAP,
    S_SEND
} state_t;

state_t state;

loader_pkg::cmd_e op_q;
logic             nak_q;        // command came in while the CPU was running
logic             rd_more_q;    // read bytes left after the one being sent
logic             fault_pend;
logic [1:0]       idx;

loader_pkg::word_t addr_q;
loader_pkg::byte_t cnt_q;
loader_pkg::byte_t wr_byte_q;
loader_pkg::byte_t tx_data_q;

logic rx_take;
logic tx_take;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshakes and RAM port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// a pending fault report goes out before the next opcode is taken
assign uart_rx_data_rdy_o = (state == S_OP && !fault_pend) || state == S_ADDR ||
                            state == S_CNT || state == S_WDATA;

assign uart_tx_data_o     = tx_data_q;
assign uart_tx_data_vld_o = (state == S_SEND);

assign rx_take = uart_rx_data_vld_i && uart_rx_data_rdy_o;
assign tx_take = uart_tx_data_vld_o && uart_tx_data_rdy_i;

assign ram_rw_sel_o     = ~cpu_run_o;
assign ram_rw_addr_o    = addr_q;
assign ram_wr_data_o    = {4{wr_byte_q}};   // the byte enable picks the lane
assign ram_wr_byte_en_o = (state == S_WSTORE && !nak_q) ? 4'b0001 << addr_q[1:0] : 4'b0000;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state      <= S_OP;
        nak_q      <= 1'b0;
        rd_more_q  <= 1'b0;
        fault_pend <= 1'b0;
        idx        <= '0;
        cpu_run_o  <= 1'b0;
    end else begin
        case (state)
            S_OP: begin
                if (fault_pend) begin
                    tx_data_q  <= loader_pkg::RSP_FAULT;
                    fault_pend <= 1'b0;
                    state      <= S_SEND;
                end else if (rx_take) begin
                    op_q  <= loader_pkg::cmd_e'(uart_rx_data_i);
                    nak_q <= cpu_run_o;
                    idx   <= '0;
                    // good responses echo the opcode
                    case (uart_rx_data_i)
                        loader_pkg::CMD_WRITE, loader_pkg::CMD_READ: begin
                            state <= S_ADDR;
                        end
                        loader_pkg::CMD_RUN: begin
                            tx_data_q <= cpu_run_o ? loader_pkg::RSP_NAK : loader_pkg::CMD_RUN;
                            cpu_run_o <= 1'b1;
                            state     <= S_SEND;
                        end
                        loader_pkg::CMD_HALT: begin
                            tx_data_q <= loader_pkg::CMD_HALT;
                            cpu_run_o <= 1'b0;
                            state     <= S_SEND;
                        end
                        default: begin
                            tx_data_q <= loader_pkg::RSP_NAK;
                            state     <= S_SEND;
                        end
                    endcase
                end
            end
            S_ADDR: begin
                if (rx_take) begin
                    addr_q[8*idx +: 8] <= uart_rx_data_i;   // little-endian
                    idx                <= idx + 1'b1;
                    if (idx == 2'd3) begin
                        state <= S_CNT;
                    end
                end
            end
            S_CNT: begin
                if (rx_take) begin
                    cnt_q <= uart_rx_data_i;
                    if (uart_rx_data_i == 8'd0) begin
                        tx_data_q <= loader_pkg::RSP_NAK;
                        state     <= S_SEND;
                    end else if (op_q == loader_pkg::CMD_WRITE) begin
                        // data bytes are swallowed even when refused
                        state <= S_WDATA;
                    end else if (nak_q) begin
                        tx_data_q <= loader_pkg::RSP_NAK;
                        state     <= S_SEND;
                    end else begin
                        state <= S_RADDR;
                    end
                end
            end
            S_WDATA: begin
                if (rx_take) begin
                    wr_byte_q <= uart_rx_data_i;
                    state     <= S_WSTORE;
                end
            end
            S_WSTORE: begin
                addr_q <= addr_q + 32'd1;
                cnt_q  <= cnt_q - 8'd1;
                if (cnt_q == 8'd1) begin
                    tx_data_q <= nak_q ? loader_pkg::RSP_NAK : loader_pkg::CMD_WRITE;
                    state     <= S_SEND;
                end else begin
                    state <= S_WDATA;
                end
            end
            S_RADDR: begin
                state <= S_RCAP;    // RAM registers the word at this edge
            end
            S_RCAP: begin
                tx_data_q <= ram_rd_data_i[8*addr_q[1:0] +: 8];
                addr_q    <= addr_q + 32'd1;
                cnt_q     <= cnt_q - 8'd1;
                rd_more_q <= (cnt_q != 8'd1);
                state     <= S_SEND;
            end
            default: begin
                if (tx_take) begin
                    rd_more_q <= 1'b0;
                    state     <= rd_more_q ? S_RADDR : S_OP;
                end
            end
        endcase

        // a fault stops the CPU at once, the report waits for the FSM to idle
        if (cpu_fault_i && cpu_run_o) begin
            cpu_run_o  <= 1'b0;
            fault_pend <= 1'b1;
        end
    end
end

endmodule

//--- logic/top_cmod.sv
module top_cmod (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              uart_rx_i,
    output logic              uart_tx_o,

    input  loader_pkg::word_t iram_rd_addr_i,
    output loader_pkg::word_t iram_rd_data_o,

    input  loader_pkg::word_t dram_rd_addr_i,
    input  loader_pkg::word_t dram_wr_addr_i,
    input  loader_pkg::word_t dram_wr_data_i,
    input  logic [3:0]        dram_wr_byte_en_i,
    output loader_pkg::word_t dram_rd_data_o,

    input  logic              cpu_fault_i,
    output logic              cpu_run_o
);

loader_pkg::byte_t uart_rx_data;
logic              uart_rx_data_vld;
logic              uart_rx_data_rdy;

loader_pkg::byte_t uart_tx_data;
logic              uart_tx_data_vld;
logic              uart_tx_data_rdy;

logic              ram_rw_sel;
loader_pkg::word_t ram_rw_addr;
loader_pkg::word_t ram_wr_data;
logic [3:0]        ram_wr_byte_en;

uart_rx uart_rx (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .uart_rx_i(uart_rx_i),
    .uart_rx_data_rdy_i(uart_rx_data_rdy),

    .uart_rx_data_o(uart_rx_data),
    .uart_rx_data_vld_o(uart_rx_data_vld)
);

uart_tx uart_tx (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .uart_tx_data_i(uart_tx_data),
    .uart_tx_data_vld_i(uart_tx_data_vld),

    .uart_tx_o(uart_tx_o),
    .uart_tx_data_rdy_o(uart_tx_data_rdy)
);

// the loader reads back through the shared data port
ram_rw ram_rw (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .cpu_fault_i(cpu_fault_i),

    .uart_rx_data_i(uart_rx_data),
    .uart_rx_data_vld_i(uart_rx_data_vld),
    .uart_rx_data_rdy_o(uart_rx_data_rdy),

    .uart_tx_data_o(uart_tx_data),
    .uart_tx_data_vld_o(uart_tx_data_vld),
    .uart_tx_data_rdy_i(uart_tx_data_rdy),

    .ram_rd_data_i(dram_rd_data_o),

    .ram_rw_sel_o(ram_rw_sel),
    .ram_rw_addr_o(ram_rw_addr),
    .ram_wr_data_o(ram_wr_data),
    .ram_wr_byte_en_o(ram_wr_byte_en),

    .cpu_run_o(cpu_run_o)
);

ram ram (
    .clk_i(clk_i),

    .ram_rw_sel_i(ram_rw_sel),
    .ram_rw_addr_i(ram_rw_addr),
    .ram_wr_data_i(ram_wr_data),
    .ram_wr_byte_en_i(ram_wr_byte_en),

    .dram_rd_addr_i(dram_rd_addr_i),
    .dram_wr_addr_i(dram_wr_addr_i),
    .dram_wr_data_i(dram_wr_data_i),
    .dram_wr_byte_en_i(dram_wr_byte_en_i),

    .iram_rd_addr_i(iram_rd_addr_i),

    .iram_rd_data_o(iram_rd_data_o),
    .dram_rd_data_o(dram_rd_data_o)
);

endmodule

//--- bench/top_cmod_assert.sv
module top_cmod_assert (
    input logic              clk_i,
    input logic              reset_i,

    input logic              uart_tx_i,
    input logic              cpu_run_i,

    input loader_pkg::byte_t tx_data_i,
    input logic              tx_vld_i,
    input logic              tx_rdy_i,

    input loader_pkg::byte_t rx_data_i,
    input logic              rx_vld_i,
    input logic              rx_rdy_i
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

reset_idle: assert property (@(posedge clk_i) reset_i |=> uart_tx_i && !cpu_run_i)
    else $error("serial line not idle or CPU running right after reset");

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte handshakes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// a stalled byte must be held as it is until it is taken
tx_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_vld_i && !tx_rdy_i |=> tx_vld_i && $stable(tx_data_i))
    else $error("tx byte or valid changed while stalled");

rx_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rx_vld_i && !rx_rdy_i |=> rx_vld_i && $stable(rx_data_i))
    else $error("rx byte or valid changed while stalled");

endmodule

//--- bench/tb_top_cmod.sv
module tb_top_cmod;

logic              clk_i;
logic              reset_i;
logic              uart_rx_i;
logic              uart_tx_o;
loader_pkg::word_t iram_rd_addr_i;
loader_pkg::word_t iram_rd_data_o;
loader_pkg::word_t dram_rd_addr_i;
loader_pkg::word_t dram_wr_addr_i;
loader_pkg::word_t dram_wr_data_i;
logic [3:0]        dram_wr_byte_en_i;
loader_pkg::word_t dram_rd_data_o;
logic              cpu_fault_i;
logic              cpu_run_o;

loader_pkg::byte_t send_q[$];   // bytes of the next host command
loader_pkg::byte_t got_q[$];    // bytes the host got back
loader_pkg::byte_t model_mem [4096];

top_cmod u_top_cmod (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .uart_rx_i(uart_rx_i),
    .uart_tx_o(uart_tx_o),
    .iram_rd_addr_i(iram_rd_addr_i),
    .iram_rd_data_o(iram_rd_data_o),
    .dram_rd_addr_i(dram_rd_addr_i),
    .dram_wr_addr_i(dram_wr_addr_i),
    .dram_wr_data_i(dram_wr_data_i),
    .dram_wr_byte_en_i(dram_wr_byte_en_i),
    .dram_rd_data_o(dram_rd_data_o),
    .cpu_fault_i(cpu_fault_i),
    .cpu_run_o(cpu_run_o)
);

bind top_cmod top_cmod_assert u_top_cmod_assert (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .uart_tx_i(uart_tx_o),
    .cpu_run_i(cpu_run_o),
    .tx_data_i(uart_tx_data),
    .tx_vld_i(uart_tx_data_vld),
    .tx_rdy_i(uart_tx_data_rdy),
    .rx_data_i(uart_rx_data),
    .rx_vld_i(uart_rx_data_vld),
    .rx_rdy_i(uart_rx_data_rdy)
);

always #10 clk_i = ~clk_i;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// error reporting and compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_byte(input string test, input loader_pkg::byte_t exp,
                          input loader_pkg::byte_t act);
    if (act !== exp) begin
        fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", test, exp, act));
    end
endtask

task automatic check_word(input string test, input loader_pkg::word_t exp,
                          input loader_pkg::word_t act);
    if (act !== exp) begin
        fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", test, exp, act));
    end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
    if (act !== exp) begin
        fail_run($sformatf("CHECK FAILED %s: expected %b, actual %b", test, exp, act));
    end
endtask

// little-endian word as the host wrote it byte by byte
function automatic loader_pkg::word_t model_word(input loader_pkg::word_t addr);
    loader_pkg::word_t w;
    for (int b = 0; b < 4; b++) begin
        w[8*b +: 8] = model_mem[{addr[11:2], 2'(b)}];
    end
    return w;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host UART model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic send_byte(input loader_pkg::byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};     // stop, data, start
    for (int i = 0; i < 10; i++) begin
        @(posedge clk_i);
        uart_rx_i <= frame[i];
        repeat (loader_pkg::BAUD_DIV - 1) @(posedge clk_i);
    end
endtask

task automatic recv_byte(input string test, output loader_pkg::byte_t data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (uart_tx_o !== 1'b0) begin
        if (waited == 4000) begin
            fail_run($sformatf("%s: no start bit on uart_tx_o within 4000 cycles", test));
        end
        waited++;
        @(negedge clk_i);
    end
    repeat (loader_pkg::BAUD_DIV / 2) @(negedge clk_i);    // middle of the start bit
    if (uart_tx_o !== 1'b0) begin
        fail_run($sformatf("%s: start bit on uart_tx_o was too short", test));
    end
    for (int i = 0; i < 8; i++) begin
        repeat (loader_pkg::BAUD_DIV) @(negedge clk_i);
        data[i] = uart_tx_o;
    end
    repeat (loader_pkg::BAUD_DIV) @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
        fail_run($sformatf("%s: stop bit on uart_tx_o missing", test));
    end
endtask

task automatic queue_header(input loader_pkg::byte_t op, input loader_pkg::word_t addr,
                            input loader_pkg::byte_t cnt);
    send_q.push_back(op);
    for (int k = 0; k < 4; k++) begin
        send_q.push_back(addr[8*k +: 8]);
    end
    send_q.push_back(cnt);
endtask

// the answer may start before the last frame has fully left, so both run at once
task automatic host_command(input string test, input int n_rsp);
    got_q.delete();
    fork
        begin
            foreach (send_q[i]) begin
                send_byte(send_q[i]);
            end
        end
        begin
            loader_pkg::byte_t b;
            repeat (n_rsp) begin
                recv_byte(test, b);
                got_q.push_back(b);
            end
        end
    join
    send_q.delete();
endtask

task automatic read_and_compare(input string test, input loader_pkg::word_t addr,
                                input int n);
    queue_header(8'h02, addr, loader_pkg::byte_t'(n));
    host_command(test, n);
    for (int k = 0; k < n; k++) begin
        check_byte(test, model_mem[12'(addr + k)], got_q[k]);
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic test_reset_state();
    @(negedge clk_i);
    check_bit("reset_state uart_tx_o", 1'b1, uart_tx_o);
    check_bit("reset_state cpu_run_o", 1'b0, cpu_run_o);
endtask

task automatic test_write_read();
    loader_pkg::byte_t data;
    queue_header(8'h01, 32'h0000_0103, 8'd9);     // unaligned start, spans three words
    for (int k = 0; k < 9; k++) begin
        data = loader_pkg::byte_t'($urandom());
        send_q.push_back(data);
        model_mem[12'(32'h0000_0103 + k)] = data;
    end
    host_command("write_read write", 1);
    check_byte("write_read ack", 8'h01, got_q[0]);
    read_and_compare("write_read readback", 32'h0000_0103, 9);
endtask

task automatic test_instr_port();
    loader_pkg::word_t addr;
    for (int w = 0; w < 2; w++) begin
        addr = 32'h0000_0104 + 32'(4 * w);
        @(posedge clk_i);
        iram_rd_addr_i <= addr;
        @(posedge clk_i);
        @(negedge clk_i);
        check_word("instr_port", model_word(addr), iram_rd_data_o);
    end
endtask

task automatic test_run_cpu_write();
    loader_pkg::word_t cpu_data;
    send_q.push_back(8'h03);
    host_command("run_cpu_write run", 1);
    check_byte("run_cpu_write run ack", 8'h03, got_q[0]);
    check_bit("run_cpu_write cpu_run_o", 1'b1, cpu_run_o);
    queue_header(8'h02, 32'h0000_0104, 8'd4);
    host_command("run_cpu_write read while running", 1);
    check_byte("run_cpu_write read while running", loader_pkg::RSP_NAK, got_q[0]);

    cpu_data = $urandom();
    @(posedge clk_i);
    dram_wr_addr_i    <= 32'h0000_0104;
    dram_wr_data_i    <= cpu_data;
    dram_wr_byte_en_i <= 4'b0101;
    @(posedge clk_i);
    dram_wr_byte_en_i <= 4'b0000;
    dram_rd_addr_i    <= 32'h0000_0104;
    @(posedge clk_i);
    @(negedge clk_i);
    model_mem[12'h104] = cpu_data[7:0];
    model_mem[12'h106] = cpu_data[23:16];
    check_word("run_cpu_write dram read", model_word(32'h0000_0104), dram_rd_data_o);

    send_q.push_back(8'h04);
    host_command("run_cpu_write halt", 1);
    check_byte("run_cpu_write halt ack", 8'h04, got_q[0]);
    check_bit("run_cpu_write cpu_run_o after halt", 1'b0, cpu_run_o);
    read_and_compare("run_cpu_write readback", 32'h0000_0104, 4);
endtask

task automatic test_fault();
    loader_pkg::byte_t rsp;
    send_q.push_back(8'h03);
    host_command("fault run", 1);
    check_byte("fault run ack", 8'h03, got_q[0]);
    check_bit("fault cpu_run_o before fault", 1'b1, cpu_run_o);
    @(posedge clk_i);
    cpu_fault_i <= 1'b1;
    @(posedge clk_i);
    cpu_fault_i <= 1'b0;
    @(negedge clk_i);
    check_bit("fault cpu_run_o after fault", 1'b0, cpu_run_o);
    recv_byte("fault response", rsp);
    check_byte("fault response", loader_pkg::RSP_FAULT, rsp);
endtask

task automatic test_unknown_op();
    send_q.push_back(8'h7A);
    host_command("unknown_op", 1);
    check_byte("unknown_op nak", loader_pkg::RSP_NAK, got_q[0]);
    read_and_compare("unknown_op readback", 32'h0000_0105, 3);

    // the trailing opcode lands while the read still streams and has to wait its turn
    queue_header(8'h02, 32'h0000_0105, 8'd3);
    send_q.push_back(8'h7A);
    host_command("unknown_op stalled", 4);
    for (int k = 0; k < 3; k++) begin
        check_byte("unknown_op stalled readback",
                   model_mem[12'(32'h0000_0105 + k)], got_q[k]);
    end
    check_byte("unknown_op stalled nak", loader_pkg::RSP_NAK, got_q[3]);
endtask

initial begin
    void'($urandom(42478));
    clk_i             = 1'b0;
    reset_i           <= 1'b1;
    uart_rx_i         <= 1'b1;  // line idles high
    iram_rd_addr_i    <= '0;
    dram_rd_addr_i    <= '0;
    dram_wr_addr_i    <= '0;
    dram_wr_data_i    <= '0;
    dram_wr_byte_en_i <= 4'b0000;
    cpu_fault_i       <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_state();
    test_write_read();
    test_instr_port();
    test_run_cpu_write();
    test_fault();
    test_unknown_op();

    $display("Testbench passed");
    $finish;
end

endmodule

//--- top_cmod.f
common/loader_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/ram.sv
logic/ram_rw.sv
logic/top_cmod.sv
bench/top_cmod_assert.sv
bench/tb_top_cmod.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the loader testbench with Verilator.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_top_cmod -f top_cmod.f -o sim_top_cmod
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_top_cmod
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
